// ==== logic/matmul_pkg.sv ====
package matmul_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sizes and timing
    //////////////////////////////////////////////////////////////////////

    localparam int data_width   = 8;
    localparam int addr_width   = 10;
    localparam int stride_width = 8;
    localparam int tile_size    = 4;
    localparam int mac_stages   = 3;
    localparam int mem_latency  = 1;

    // Last operand pair meets PE(3,3) after 3*N-1 cycles, then the MAC drains
    localparam int latch_cycle  = 3 * tile_size - 1 + mac_stages;
    localparam int done_cycle   = latch_cycle + mac_stages;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    typedef logic [7:0]              cycle_t;
    typedef logic [data_width-1:0]   elem_t;
    typedef logic [addr_width-1:0]   addr_t;
    typedef logic [stride_width-1:0] stride_t;
    typedef logic [tile_size-1:0]    lane_mask_t;

    // Lane 0 sits in the least significant byte of the memory word
    typedef elem_t [tile_size-1:0] lane_vec_t;

    // Index order is [column][row], so one column is one output word
    typedef lane_vec_t [tile_size-1:0] tile_t;

    typedef enum logic [1:0] {run_idle, run_busy, run_finished} run_state_t;

    typedef enum logic [1:0] {drain_idle, drain_shift, drain_spent} drain_state_t;

endpackage

// ==== logic/operand_feed_if.sv ====
interface operand_feed_if
    import matmul_pkg::*;
();

    // Skewed operands entering the left column (A) and top row (B) of the mesh
    elem_t a_lane [tile_size];
    elem_t b_lane [tile_size];

    // Feed stage drives every lane on every cycle
    modport source (
        output a_lane,
        output b_lane
    );

    modport sink (
        input a_lane,
        input b_lane
    );

endinterface

// ==== logic/processing_element.sv ====
module processing_element
    import matmul_pkg::*;
(
    input  logic  clk,
    input  logic  clear,
    input  elem_t in_a,
    input  elem_t in_b,
    output elem_t out_a,
    output elem_t out_b,
    output elem_t acc
);

    elem_t a_reg;
    elem_t b_reg;
    elem_t product;

    // Operands move one hop per cycle toward the right and downward
    always_ff @(posedge clk) begin
        if (clear) begin
            out_a <= '0;
            out_b <= '0;
        end else begin
            out_a <= in_a;
            out_b <= in_b;
        end
    end

    // Operand capture, multiply, accumulate; the sum wraps modulo 256
    always_ff @(posedge clk) begin
        if (clear) begin
            a_reg   <= '0;
            b_reg   <= '0;
            product <= '0;
            acc     <= '0;
        end else begin
            a_reg   <= in_a;
            b_reg   <= in_b;
            product <= elem_t'(a_reg * b_reg);
            acc     <= acc + product;
        end
    end

endmodule

// ==== logic/pe_mesh.sv ====
module pe_mesh
    import matmul_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         pe_reset,
    operand_feed_if.sink feed,
    output tile_t        c_tile
);

    // Hop [i][j] feeds PE(i,j); the last hop of each row or column leaves the mesh
    elem_t a_hop [tile_size][tile_size+1];
    elem_t b_hop [tile_size+1][tile_size];
    logic  mac_clear;

    assign mac_clear = reset | pe_reset;

    for (genvar i = 0; i < tile_size; i++) begin : g_edge
        assign a_hop[i][0] = feed.a_lane[i];
        assign b_hop[0][i] = feed.b_lane[i];
    end

    //////////////////////////////////////////////////////////////////////
    // Grid of processing elements
    //////////////////////////////////////////////////////////////////////

    for (genvar i = 0; i < tile_size; i++) begin : g_row
        for (genvar j = 0; j < tile_size; j++) begin : g_col
            processing_element u_pe (
                .clk   (clk),
                .clear (mac_clear),
                .in_a  (a_hop[i][j]),
                .in_b  (b_hop[i][j]),
                .out_a (a_hop[i][j+1]),
                .out_b (b_hop[i+1][j]),
                .acc   (c_tile[j][i])
            );
        end
    end

endmodule

// ==== logic/matmul_sequencer.sv ====
module matmul_sequencer
    import matmul_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   start_mat_mul,
    output cycle_t run_count,
    output logic   done_mat_mul
);

    run_state_t run_state;

    // The count follows the number of edges seen with start high
    always_ff @(posedge clk) begin
        if (reset || !start_mat_mul) begin
            run_state    <= run_idle;
            run_count    <= '0;
            done_mat_mul <= 1'b0;
        end else begin
            case (run_state)
                run_idle: begin
                    run_state <= run_busy;
                    run_count <= run_count + 1'b1;
                end
                run_busy: begin
                    run_count <= run_count + 1'b1;
                    if (run_count == done_cycle) begin
                        done_mat_mul <= 1'b1;
                        run_state    <= run_finished;
                    end
                end
                // Count freezes here until start drops
                default: done_mat_mul <= 1'b0;
            endcase
        end
    end

    a_done_single: assert property (@(posedge clk) disable iff (reset)
        done_mat_mul |=> !done_mat_mul);

    a_count_frozen: assert property (@(posedge clk) disable iff (reset)
        (run_state == run_finished && start_mat_mul) |=> $stable(run_count));

endmodule

// ==== logic/systolic_feed.sv ====
module systolic_feed
    import matmul_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  logic          start_mat_mul,
    input  cycle_t        run_count,
    input  addr_t         address_mat_a,
    input  addr_t         address_mat_b,
    input  stride_t       address_stride_a,
    input  stride_t       address_stride_b,
    input  lane_vec_t     a_data,
    input  lane_vec_t     b_data,
    input  lane_mask_t    validity_mask_a_rows,
    input  lane_mask_t    validity_mask_a_cols_b_rows,
    input  lane_mask_t    validity_mask_b_cols,
    output addr_t         a_addr,
    output addr_t         b_addr,
    operand_feed_if.source feed
);

    logic   window_open;
    logic   mem_access;
    cycle_t access_count;
    logic   data_valid;
    addr_t  a_rest;
    addr_t  b_rest;
    elem_t  a_q [tile_size];
    elem_t  b_q [tile_size];

    //////////////////////////////////////////////////////////////////////
    // Address generation, shared window for A and B
    //////////////////////////////////////////////////////////////////////

    assign window_open = run_count < cycle_t'(tile_size);
    assign a_rest = address_mat_a - addr_t'(address_stride_a);
    assign b_rest = address_mat_b - addr_t'(address_stride_b);

    // Resting one stride below base lets the first step land on base
    always_ff @(posedge clk) begin
        if (reset || !start_mat_mul || !window_open) begin
            a_addr     <= a_rest;
            b_addr     <= b_rest;
            mem_access <= 1'b0;
        end else begin
            a_addr     <= a_addr + addr_t'(address_stride_a);
            b_addr     <= b_addr + addr_t'(address_stride_b);
            mem_access <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset || !start_mat_mul || !mem_access) begin
            access_count <= '0;
        end else begin
            access_count <= access_count + 1'b1;
        end
    end

    // Word k of both matrices shows up when the counter reaches k + latency
    always_comb begin
        data_valid = 1'b0;
        for (int k = 0; k < tile_size; k++) begin
            if (access_count == cycle_t'(k + mem_latency)) begin
                data_valid = validity_mask_a_cols_b_rows[k];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Qualification and skew
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < tile_size; i++) begin
            a_q[i] = a_data[i] & {data_width{data_valid & validity_mask_a_rows[i]}};
            b_q[i] = b_data[i] & {data_width{data_valid & validity_mask_b_cols[i]}};
        end
    end

    assign feed.a_lane[0] = a_q[0];
    assign feed.b_lane[0] = b_q[0];

    // Lane i waits i cycles so operands meet on the mesh diagonals
    for (genvar i = 1; i < tile_size; i++) begin : g_skew
        elem_t a_line [i];
        elem_t b_line [i];

        always_ff @(posedge clk) begin
            if (reset || !start_mat_mul || run_count == '0) begin
                for (int d = 0; d < i; d++) begin
                    a_line[d] <= '0;
                    b_line[d] <= '0;
                end
            end else begin
                a_line[0] <= a_q[i];
                b_line[0] <= b_q[i];
                for (int d = 1; d < i; d++) begin
                    a_line[d] <= a_line[d-1];
                    b_line[d] <= b_line[d-1];
                end
            end
        end

        assign feed.a_lane[i] = a_line[i-1];
        assign feed.b_lane[i] = b_line[i-1];
    end

    a_addr_rests: assert property (@(posedge clk) disable iff (reset)
        (!start_mat_mul || !window_open) |=> a_addr == $past(a_rest));

endmodule

// ==== logic/result_drain.sv ====
module result_drain
    import matmul_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      start_mat_mul,
    input  logic      done_mat_mul,
    input  cycle_t    run_count,
    input  tile_t     c_tile,
    input  addr_t     address_mat_c,
    input  stride_t   address_stride_c,
    output lane_vec_t c_data_out,
    output addr_t     c_addr,
    output logic      c_data_available
);

    drain_state_t drain_state;
    lane_vec_t    pending [tile_size-1];
    logic         capture;
    addr_t        c_step;

    assign c_step  = addr_t'(address_stride_c);
    assign capture = start_mat_mul && drain_state == drain_idle && run_count == latch_cycle;

    //////////////////////////////////////////////////////////////////////
    // Output sequencing
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset || !start_mat_mul) begin
            drain_state      <= drain_idle;
            c_data_available <= 1'b0;
            c_data_out       <= '0;
            c_addr           <= address_mat_c - c_step;
        end else begin
            case (drain_state)
                drain_idle: begin
                    if (capture) begin
                        drain_state      <= drain_shift;
                        c_data_available <= 1'b1;
                        c_data_out       <= c_tile[0];
                        c_addr           <= c_addr + c_step;
                    end
                end
                drain_shift: begin
                    if (done_mat_mul) begin
                        drain_state      <= drain_spent;
                        c_data_available <= 1'b0;
                        c_data_out       <= '0;
                        c_addr           <= address_mat_c - c_step;
                    end else begin
                        c_data_out <= pending[0];
                        c_addr     <= c_addr + c_step;
                    end
                end
                default: drain_state <= drain_spent;
            endcase
        end
    end

    // Columns 1 to 3 wait here and move one slot per cycle, zeros behind them
    always_ff @(posedge clk) begin
        if (capture) begin
            for (int j = 1; j < tile_size; j++) begin
                pending[j-1] <= c_tile[j];
            end
        end else begin
            for (int j = 0; j < tile_size - 2; j++) begin
                pending[j] <= pending[j+1];
            end
            pending[tile_size-2] <= '0;
        end
    end

    a_idle_quiet: assert property (@(posedge clk) disable iff (reset)
        !start_mat_mul |=> !c_data_available);

endmodule

// ==== logic/matmul_4x4_systolic.sv ====
module matmul_4x4_systolic
    import matmul_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       pe_reset,
    input  logic       start_mat_mul,
    input  addr_t      address_mat_a,
    input  addr_t      address_mat_b,
    input  addr_t      address_mat_c,
    input  stride_t    address_stride_a,
    input  stride_t    address_stride_b,
    input  stride_t    address_stride_c,
    input  lane_vec_t  a_data,
    input  lane_vec_t  b_data,
    input  lane_mask_t validity_mask_a_rows,
    input  lane_mask_t validity_mask_a_cols_b_rows,
    input  lane_mask_t validity_mask_b_cols,
    output logic       done_mat_mul,
    output logic       c_data_available,
    output addr_t      a_addr,
    output addr_t      b_addr,
    output addr_t      c_addr,
    output lane_vec_t  c_data_out
);

    cycle_t run_count;
    tile_t  c_tile;

    operand_feed_if feed ();

    matmul_sequencer u_matmul_sequencer (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .run_count     (run_count),
        .done_mat_mul  (done_mat_mul)
    );

    //////////////////////////////////////////////////////////////////////
    // Datapath from memories through the mesh to the C port
    //////////////////////////////////////////////////////////////////////

    systolic_feed u_systolic_feed (
        .clk                         (clk),
        .reset                       (reset),
        .start_mat_mul               (start_mat_mul),
        .run_count                   (run_count),
        .address_mat_a               (address_mat_a),
        .address_mat_b               (address_mat_b),
        .address_stride_a            (address_stride_a),
        .address_stride_b            (address_stride_b),
        .a_data                      (a_data),
        .b_data                      (b_data),
        .validity_mask_a_rows        (validity_mask_a_rows),
        .validity_mask_a_cols_b_rows (validity_mask_a_cols_b_rows),
        .validity_mask_b_cols        (validity_mask_b_cols),
        .a_addr                      (a_addr),
        .b_addr                      (b_addr),
        .feed                        (feed.source)
    );

    pe_mesh u_pe_mesh (
        .clk      (clk),
        .reset    (reset),
        .pe_reset (pe_reset),
        .feed     (feed.sink),
        .c_tile   (c_tile)
    );

    result_drain u_result_drain (
        .clk              (clk),
        .reset            (reset),
        .start_mat_mul    (start_mat_mul),
        .done_mat_mul     (done_mat_mul),
        .run_count        (run_count),
        .c_tile           (c_tile),
        .address_mat_c    (address_mat_c),
        .address_stride_c (address_stride_c),
        .c_data_out       (c_data_out),
        .c_addr           (c_addr),
        .c_data_available (c_data_available)
    );

endmodule

// ==== sim/matmul_tb.sv ====
module matmul_tb
    import matmul_pkg::*;
();

    localparam int run_timeout = 64;

    logic       clk = 1'b0;
    logic       reset;
    logic       pe_reset;
    logic       start_mat_mul;
    addr_t      address_mat_a, address_mat_b, address_mat_c;
    stride_t    address_stride_a, address_stride_b, address_stride_c;
    lane_vec_t  a_data = '0;
    lane_vec_t  b_data = '0;
    lane_mask_t validity_mask_a_rows, validity_mask_a_cols_b_rows, validity_mask_b_cols;
    logic       done_mat_mul;
    logic       c_data_available;
    addr_t      a_addr, b_addr, c_addr;
    lane_vec_t  c_data_out;

    logic [31:0] mem_a [1024];
    logic [31:0] mem_b [1024];
    elem_t       mat_a [tile_size][tile_size];
    elem_t       mat_b [tile_size][tile_size];
    logic [31:0] rng_state = 32'h516400d9;

    // What one run put on the outputs, sampled on the falling edge
    lane_vec_t c_words [$];
    addr_t     c_addrs [$];
    addr_t     a_issued [$];
    addr_t     b_issued [$];
    int        avail_first, avail_last, done_count, done_edge;
    int        error_count = 0;
    int        test_errors = 0;
    int        test_count = 0;

    matmul_4x4_systolic i_matmul_4x4_systolic (.*);

    always #2 clk = ~clk;

    // Both memories answer one cycle after the address
    always @(posedge clk) begin
        a_data <= mem_a[a_addr];
        b_data <= mem_b[b_addr];
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers and reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] state);
        logic [31:0] x;
        x = state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic elem_t next_byte();
        rng_state = xorshift32(rng_state);
        return rng_state[15:8];
    endfunction

    function automatic logic [31:0] fill_word(input addr_t ad, input logic which);
        return {ad, 6'h15, ~ad, 5'h0a, which};
    endfunction

    function automatic addr_t step_address(input addr_t base, input stride_t stride, input int k);
        return base + addr_t'(k) * addr_t'(stride);
    endfunction

    // Column j of C, with masked rows, columns and k terms left out
    function automatic lane_vec_t model_column(input int j);
        lane_vec_t col;
        int        sum;
        for (int i = 0; i < tile_size; i++) begin
            sum = 0;
            for (int k = 0; k < tile_size; k++) begin
                if (validity_mask_a_cols_b_rows[k]) begin
                    sum = sum + int'(mat_a[i][k]) * int'(mat_b[k][j]);
                end
            end
            if (!validity_mask_a_rows[i] || !validity_mask_b_cols[j]) begin
                sum = 0;
            end
            col[i] = elem_t'(sum);
        end
        return col;
    endfunction

    task automatic flag_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        $display("ERROR t=%0t %s expected %h got %h", $time, name, expected, actual);
        error_count++;
        test_errors++;
    endtask

    task automatic note_failure(input string what);
        $display("t=%0t %s", $time, what);
        error_count++;
        test_errors++;
    endtask

    task automatic close_test(input string name);
        test_count++;
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic configure_run(input addr_t base_a, input addr_t base_b, input addr_t base_c,
                                 input stride_t step_a, input stride_t step_b,
                                 input stride_t step_c, input lane_mask_t rows,
                                 input lane_mask_t ks, input lane_mask_t cols);
        @(posedge clk);
        address_mat_a               <= base_a;
        address_mat_b               <= base_b;
        address_mat_c               <= base_c;
        address_stride_a            <= step_a;
        address_stride_b            <= step_b;
        address_stride_c            <= step_c;
        validity_mask_a_rows        <= rows;
        validity_mask_a_cols_b_rows <= ks;
        validity_mask_b_cols        <= cols;
        @(posedge clk);
    endtask

    task automatic randomize_operands(input bit identity_a);
        for (int i = 0; i < tile_size; i++) begin
            for (int k = 0; k < tile_size; k++) begin
                mat_a[i][k] = identity_a ? elem_t'(i == k) : next_byte();
                mat_b[i][k] = next_byte();
            end
        end
    endtask

    // Word k of A is column k, word k of B is row k
    task automatic load_memories();
        lane_vec_t a_word;
        lane_vec_t b_word;
        for (int k = 0; k < tile_size; k++) begin
            for (int i = 0; i < tile_size; i++) begin
                a_word[i] = mat_a[i][k];
                b_word[i] = mat_b[k][i];
            end
            mem_a[step_address(address_mat_a, address_stride_a, k)] = a_word;
            mem_b[step_address(address_mat_b, address_stride_b, k)] = b_word;
        end
    endtask

    task automatic execute_run(input bit clear_first);
        int   edge_n;
        logic finished;
        c_words.delete();
        c_addrs.delete();
        a_issued.delete();
        b_issued.delete();
        avail_first = -1;
        avail_last  = -1;
        done_count  = 0;
        done_edge   = -1;
        load_memories();
        @(posedge clk);
        pe_reset <= clear_first;
        @(posedge clk);
        pe_reset      <= 1'b0;
        start_mat_mul <= 1'b1;
        @(negedge clk);
        edge_n   = 0;
        finished = 1'b0;
        // Sampling goes on a few cycles past done to catch a second pulse
        while (!finished && edge_n < run_timeout) begin
            @(negedge clk);
            edge_n++;
            if (edge_n <= tile_size) begin
                a_issued.push_back(a_addr);
                b_issued.push_back(b_addr);
            end
            if (c_data_available) begin
                if (avail_first < 0) begin
                    avail_first = edge_n;
                end
                avail_last = edge_n;
                c_words.push_back(c_data_out);
                c_addrs.push_back(c_addr);
            end
            if (done_mat_mul) begin
                done_count++;
                if (done_edge < 0) begin
                    done_edge = edge_n;
                end
            end
            finished = done_edge >= 0 && edge_n >= done_edge + 4;
        end
        if (!finished) begin
            note_failure("timeout, done_mat_mul did not pulse within 64 cycles");
        end
        @(posedge clk);
        start_mat_mul <= 1'b0;
    endtask

    task automatic check_against_model();
        if (c_words.size() != tile_size) begin
            note_failure($sformatf("expected 4 words of C, saw %0d", c_words.size()));
        end else begin
            for (int j = 0; j < tile_size; j++) begin
                if (c_words[j] !== model_column(j)) begin
                    flag_mismatch($sformatf("c_data_out col %0d", j), model_column(j),
                                  c_words[j]);
                end
            end
        end
    endtask

    task automatic check_idle(input int cycles);
        @(posedge clk);
        for (int n = 0; n < cycles; n++) begin
            @(negedge clk);
            if (done_mat_mul !== 1'b0) begin
                flag_mismatch("done_mat_mul", 0, 32'(done_mat_mul));
            end
            if (c_data_available !== 1'b0) begin
                flag_mismatch("c_data_available", 0, 32'(c_data_available));
            end
            if (c_data_out !== '0) begin
                flag_mismatch("c_data_out", 0, c_data_out);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic idle_and_pe_reset();
        check_idle(4);
        configure_run(10'h000, 10'h100, 10'h200, 8'd1, 8'd1, 8'd1, 4'hf, 4'hf, 4'hf);
        randomize_operands(1'b0);
        execute_run(1'b0);
        check_idle(4);
        // Accumulators still hold the first product until pe_reset clears them
        randomize_operands(1'b0);
        execute_run(1'b1);
        check_against_model();
        close_test("idle_and_pe_reset");
    endtask

    task automatic identity_times_random();
        lane_vec_t col;
        configure_run(10'h000, 10'h040, 10'h080, 8'd1, 8'd1, 8'd1, 4'hf, 4'hf, 4'hf);
        randomize_operands(1'b1);
        execute_run(1'b1);
        if (c_words.size() != tile_size) begin
            note_failure($sformatf("expected 4 words of C, saw %0d", c_words.size()));
        end else begin
            for (int j = 0; j < tile_size; j++) begin
                for (int i = 0; i < tile_size; i++) begin
                    col[i] = mat_b[i][j];
                end
                if (c_words[j] !== col) begin
                    flag_mismatch($sformatf("c_data_out col %0d", j), col, c_words[j]);
                end
            end
        end
        close_test("identity_times_random");
    endtask

    task automatic strided_product();
        configure_run(10'h103, 10'h2f0, 10'h0a0, 8'd5, 8'd33, 8'd7, 4'hf, 4'hf, 4'hf);
        randomize_operands(1'b0);
        execute_run(1'b1);
        check_against_model();
        for (int k = 0; k < tile_size; k++) begin
            if (a_issued[k] !== step_address(address_mat_a, address_stride_a, k)) begin
                flag_mismatch($sformatf("a_addr step %0d", k),
                              32'(step_address(address_mat_a, address_stride_a, k)),
                              32'(a_issued[k]));
            end
            if (b_issued[k] !== step_address(address_mat_b, address_stride_b, k)) begin
                flag_mismatch($sformatf("b_addr step %0d", k),
                              32'(step_address(address_mat_b, address_stride_b, k)),
                              32'(b_issued[k]));
            end
            if (k < c_addrs.size() &&
                c_addrs[k] !== step_address(address_mat_c, address_stride_c, k)) begin
                flag_mismatch($sformatf("c_addr col %0d", k),
                              32'(step_address(address_mat_c, address_stride_c, k)),
                              32'(c_addrs[k]));
            end
        end
        close_test("strided_product");
    endtask

    task automatic masked_product();
        // Row 2 of A, k term 1 and column 3 of B are switched off
        configure_run(10'h010, 10'h050, 10'h090, 8'd2, 8'd3, 8'd1, 4'b1011, 4'b1101, 4'b0111);
        randomize_operands(1'b0);
        execute_run(1'b1);
        check_against_model();
        if (c_words.size() == tile_size) begin
            for (int j = 0; j < tile_size; j++) begin
                if (c_words[j][2] !== 8'h00) begin
                    flag_mismatch($sformatf("c_data_out col %0d row 2", j), 0, 32'(c_words[j][2]));
                end
            end
            if (c_words[3] !== '0) begin
                flag_mismatch("c_data_out col 3", 0, c_words[3]);
            end
        end
        close_test("masked_product");
    endtask

    task automatic done_and_available();
        configure_run(10'h300, 10'h340, 10'h380, 8'd1, 8'd1, 8'd1, 4'hf, 4'hf, 4'hf);
        randomize_operands(1'b0);
        execute_run(1'b1);
        if (c_words.size() != tile_size || avail_last - avail_first + 1 != tile_size) begin
            note_failure("c_data_available was not high for four consecutive cycles");
        end
        if (done_count != 1) begin
            flag_mismatch("done_mat_mul pulse count", 1, 32'(done_count));
        end
        if (done_edge != avail_last) begin
            flag_mismatch("done_mat_mul cycle", 32'(avail_last), 32'(done_edge));
        end
        check_idle(3);
        close_test("done_and_available");
    endtask

    initial begin
        reset                       = 1'b1;
        pe_reset                    = 1'b0;
        start_mat_mul               = 1'b0;
        address_mat_a               = '0;
        address_mat_b               = '0;
        address_mat_c               = '0;
        address_stride_a            = 8'd1;
        address_stride_b            = 8'd1;
        address_stride_c            = 8'd1;
        validity_mask_a_rows        = '1;
        validity_mask_a_cols_b_rows = '1;
        validity_mask_b_cols        = '1;
        for (int n = 0; n < 1024; n++) begin
            mem_a[n] = fill_word(addr_t'(n), 1'b0);
            mem_b[n] = fill_word(addr_t'(n), 1'b1);
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        idle_and_pe_reset();
        identity_times_random();
        strided_product();
        masked_product();
        done_and_available();

        $display("%0d tests run, %0d errors", test_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
logic/matmul_pkg.sv
logic/operand_feed_if.sv
logic/processing_element.sv
logic/pe_mesh.sv
logic/matmul_sequencer.sv
logic/systolic_feed.sv
logic/result_drain.sv
logic/matmul_4x4_systolic.sv
sim/matmul_tb.sv

// ==== Makefile ====
SOURCES := sources.f $(wildcard logic/*.sv sim/*.sv)

.PHONY: run clean

run: obj_dir/Vmatmul_tb
	@out="$$(./obj_dir/Vmatmul_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "ALL CHECKS PASSED"

obj_dir/Vmatmul_tb: $(SOURCES)
	verilator --binary --timing --assert -j 0 --top-module matmul_tb -f sources.f

clean:
	rm -rf obj_dir
